//--- verilog/jtag_defs.svh
`ifndef JTAG_DEFS_SVH
`define JTAG_DEFS_SVH

// Size of each scan buffer in bytes
`define JTAG_MEM_BYTES 16

// Bus address width
`define JTAG_ABUSWIDTH 16

// Returned on a read of address 0
`define JTAG_VERSION 1

// TCK cycles with TMS high in Test-Logic-Reset
`define JTAG_RESET_TMS 5

`endif

//--- verilog/jtag_pkg.sv
package jtag_pkg;

`include "jtag_defs.svh"

    localparam int BYTE_AW = $clog2(`JTAG_MEM_BYTES);
    localparam int BIT_AW = BYTE_AW + 3;   // Stream bit address

    // IEEE 1149.1 TAP states
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    typedef struct packed {
        logic [15:0] bit_count;
        logic [31:0] wait_count;   // Zero bits after the data bits
        logic [15:0] word_count;
        logic        ir_scan;
    } jtag_conf_t;

    // Sequencer output, sampled by the pin driver on the falling edge
    typedef struct packed {
        logic              tms;
        logic              sen;
        logic              shifting;
        logic              data_bit;
        logic [BIT_AW-1:0] bit_addr;
    } shift_ctrl_t;

endpackage

//--- verilog/jtag_regs.sv
`timescale 1ns/1ps
`include "jtag_defs.svh"

module jtag_regs (
    input  logic                           JTAG_CLK,
    input  logic                           RST_SYNC,
    input  logic [`JTAG_ABUSWIDTH-1:0]     bus_add,
    input  logic [7:0]                     bus_data_in,
    input  logic                           bus_wr,
    input  logic                           bus_rd,
    input  logic [7:0]                     in_mem_data,
    input  logic [7:0]                     out_mem_data,
    input  logic                           done,
    output jtag_pkg::jtag_conf_t           conf,
    output logic                           start,
    output logic                           core_rst,
    output logic                           out_mem_we,
    output logic [jtag_pkg::BYTE_AW-1:0]   out_mem_addr,
    output logic [7:0]                     bus_data_out
);

    localparam int AW = `JTAG_ABUSWIDTH;
    localparam int MEM = `JTAG_MEM_BYTES;
    localparam logic [15:0] MEM_SIZE = 16'(`JTAG_MEM_BYTES);
    localparam logic [15:0] DEF_BITS = 16'(8 * `JTAG_MEM_BYTES);
    localparam logic [7:0] VERSION = 8'(`JTAG_VERSION);

    localparam logic [1:0] SEL_REG = 2'd0;
    localparam logic [1:0] SEL_OUT = 2'd1;
    localparam logic [1:0] SEL_IN  = 2'd2;
    localparam logic [1:0] SEL_NONE = 2'd3;

    logic [7:0] regs [16];
    logic rst;
    logic soft_wr;
    logic start_wr;
    logic done_flag;
    logic out_region;
    logic in_region;
    logic [AW-1:0] mem_offset;
    logic [jtag_pkg::BYTE_AW-1:0] addr_q;
    logic [7:0] reg_rdata;
    logic [1:0] rd_sel;

    assign soft_wr = bus_wr && (bus_add == AW'(0));
    assign start_wr = bus_wr && (bus_add == AW'(1));
    assign rst = RST_SYNC || soft_wr;

    assign out_region = (bus_add >= AW'(16)) && (bus_add < AW'(16 + MEM));
    assign in_region = (bus_add >= AW'(16 + MEM)) && (bus_add < AW'(16 + 2 * MEM));
    assign mem_offset = out_region ? bus_add - AW'(16) : bus_add - AW'(16 + MEM);

    // Shared byte address for both buffers, held between reads
    assign out_mem_we = bus_wr && out_region;
    assign out_mem_addr = (bus_rd || out_mem_we) ? mem_offset[jtag_pkg::BYTE_AW-1:0] : addr_q;

    assign conf.bit_count = {regs[4], regs[3]};
    assign conf.wait_count = {regs[8], regs[7], regs[6], regs[5]};
    assign conf.word_count = {regs[10], regs[9]};
    assign conf.ir_scan = ({regs[12], regs[11]} == 16'd0);   // Op code 0 is IR

    always_ff @(posedge JTAG_CLK)
    begin
        if (rst)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= 8'h00;
            regs[3] <= DEF_BITS[7:0];
            regs[4] <= DEF_BITS[15:8];
            regs[9] <= 8'd1;   // One word
            start <= 1'b0;
            done_flag <= 1'b0;
        end
        else
        begin
            if (bus_wr && bus_add < AW'(16))
                regs[bus_add[3:0]] <= bus_data_in;
            start <= start_wr;
            if (start_wr)
                done_flag <= 1'b0;
            else if (done)
                done_flag <= 1'b1;
        end
    end

    // Downstream stages see the reset one cycle later
    always_ff @(posedge JTAG_CLK)
        core_rst <= rst;

    always_ff @(posedge JTAG_CLK)
    begin
        if (bus_rd)
        begin
            addr_q <= mem_offset[jtag_pkg::BYTE_AW-1:0];
            if (bus_add < AW'(16))
                rd_sel <= SEL_REG;
            else if (out_region)
                rd_sel <= SEL_OUT;
            else if (in_region)
                rd_sel <= SEL_IN;
            else
                rd_sel <= SEL_NONE;
            case (bus_add)
                AW'(0):  reg_rdata <= VERSION;
                AW'(1):  reg_rdata <= {7'b0, done_flag};
                AW'(13): reg_rdata <= {7'b0, regs[13][0]};
                AW'(14): reg_rdata <= MEM_SIZE[7:0];
                AW'(15): reg_rdata <= MEM_SIZE[15:8];
                default: reg_rdata <= regs[bus_add[3:0]];
            endcase
        end
    end

    always_comb
    begin
        case (rd_sel)
            SEL_REG: bus_data_out = reg_rdata;
            SEL_OUT: bus_data_out = out_mem_data;
            SEL_IN:  bus_data_out = in_mem_data;
            default: bus_data_out = 8'h00;
        endcase
    end

    // Buffer address is shared, so read and write strobes must not overlap
    a_no_rd_wr: assert property (@(posedge JTAG_CLK) disable iff (RST_SYNC)
        !(bus_wr && bus_rd));

endmodule

//--- verilog/jtag_bit_mem.sv
`timescale 1ns/1ps

module jtag_bit_mem (
    input  logic                           JTAG_CLK,
    input  logic                           byte_we,
    input  logic [jtag_pkg::BYTE_AW-1:0]   byte_addr,
    input  logic [7:0]                     byte_wdata,
    output logic [7:0]                     byte_rdata,
    input  logic                           bit_we,
    input  logic [jtag_pkg::BIT_AW-1:0]    bit_addr,
    input  logic                           bit_wdata,
    output logic                           bit_rdata
);

    localparam int NBITS = 1 << jtag_pkg::BIT_AW;

    // Stream bit j lives in byte j/8 at bit 7-j%8
    logic mem [NBITS];

    always_ff @(posedge JTAG_CLK)
    begin
        if (byte_we)
        begin
            for (int i = 0; i < 8; i++)
                mem[{byte_addr, 3'(7 - i)}] <= byte_wdata[i];
        end
        if (bit_we)
            mem[bit_addr] <= bit_wdata;
    end

    always_ff @(posedge JTAG_CLK)
    begin
        for (int i = 0; i < 8; i++)
            byte_rdata[i] <= mem[{byte_addr, 3'(7 - i)}];
    end

    assign bit_rdata = mem[bit_addr];   // Scan side reads without latency

endmodule

//--- verilog/jtag_tap_sequencer.sv
`timescale 1ns/1ps
`include "jtag_defs.svh"

module jtag_tap_sequencer (
    input  logic                    JTAG_CLK,
    input  logic                    core_rst,
    input  jtag_pkg::jtag_conf_t    conf,
    input  logic                    start,
    output jtag_pkg::shift_ctrl_t   ctrl,
    output logic                    done
);

    localparam logic [7:0] RESET_TMS = 8'(`JTAG_RESET_TMS);

    jtag_pkg::tap_state_e state;
    jtag_pkg::tap_state_e state_nxt;
    logic [32:0] bit_cnt;
    logic [32:0] shift_len;
    logic [15:0] word_cnt;
    logic [31:0] word_base;    // Stream index of the current word's first bit
    logic [31:0] addr_full;
    logic [7:0] rst_cnt;
    logic active;
    logic last_shift;
    logic launch;
    logic more_words;
    logic scan_done;
    logic reset_done;

    assign shift_len = {1'b0, conf.bit_count} + {1'b0, conf.wait_count};
    assign last_shift = (bit_cnt + 33'd1) >= shift_len;

    // Start only counts when idle
    assign launch = start && !active && (state == jtag_pkg::RUN_TEST_IDLE);
    assign more_words = active && (word_cnt != conf.word_count);
    assign scan_done = active && (word_cnt == conf.word_count)
                       && (state == jtag_pkg::RUN_TEST_IDLE);
    assign reset_done = (state == jtag_pkg::TEST_LOGIC_RESET) && (rst_cnt == RESET_TMS);

    always_comb
    begin
        state_nxt = state;
        case (state)
            jtag_pkg::TEST_LOGIC_RESET:
                if (rst_cnt == RESET_TMS)
                    state_nxt = jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::RUN_TEST_IDLE:
                if ((launch && conf.word_count != 16'd0) || more_words)
                    state_nxt = jtag_pkg::SELECT_DR_SCAN;
            jtag_pkg::SELECT_DR_SCAN:
                state_nxt = conf.ir_scan ? jtag_pkg::SELECT_IR_SCAN : jtag_pkg::CAPTURE_DR;
            jtag_pkg::CAPTURE_DR:     state_nxt = jtag_pkg::SHIFT_DR;
            jtag_pkg::SHIFT_DR:
                if (last_shift)
                    state_nxt = jtag_pkg::EXIT1_DR;
            jtag_pkg::EXIT1_DR:       state_nxt = jtag_pkg::UPDATE_DR;
            jtag_pkg::PAUSE_DR:       state_nxt = jtag_pkg::EXIT2_DR;
            jtag_pkg::EXIT2_DR:       state_nxt = jtag_pkg::UPDATE_DR;
            jtag_pkg::UPDATE_DR:      state_nxt = jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::SELECT_IR_SCAN: state_nxt = jtag_pkg::CAPTURE_IR;
            jtag_pkg::CAPTURE_IR:     state_nxt = jtag_pkg::SHIFT_IR;
            jtag_pkg::SHIFT_IR:
                if (last_shift)
                    state_nxt = jtag_pkg::EXIT1_IR;
            jtag_pkg::EXIT1_IR:       state_nxt = jtag_pkg::UPDATE_IR;
            jtag_pkg::PAUSE_IR:       state_nxt = jtag_pkg::EXIT2_IR;
            jtag_pkg::EXIT2_IR:       state_nxt = jtag_pkg::UPDATE_IR;
            jtag_pkg::UPDATE_IR:      state_nxt = jtag_pkg::RUN_TEST_IDLE;
            default:                  state_nxt = jtag_pkg::TEST_LOGIC_RESET;
        endcase
    end

    // TMS that moves the target along with state_nxt
    assign ctrl.tms = state_nxt inside {jtag_pkg::TEST_LOGIC_RESET, jtag_pkg::SELECT_DR_SCAN,
                                        jtag_pkg::SELECT_IR_SCAN, jtag_pkg::EXIT1_DR,
                                        jtag_pkg::EXIT1_IR, jtag_pkg::EXIT2_DR,
                                        jtag_pkg::EXIT2_IR, jtag_pkg::UPDATE_DR,
                                        jtag_pkg::UPDATE_IR};
    assign ctrl.sen = !((state == jtag_pkg::RUN_TEST_IDLE)
                        && (state_nxt == jtag_pkg::RUN_TEST_IDLE));
    assign ctrl.shifting = state inside {jtag_pkg::SHIFT_DR, jtag_pkg::SHIFT_IR};
    assign ctrl.data_bit = ctrl.shifting && (bit_cnt < {17'd0, conf.bit_count});

    // Words go out MSB first from the top of their slice
    assign addr_full = word_base + 32'(conf.bit_count) - 32'd1 - bit_cnt[31:0];
    assign ctrl.bit_addr = addr_full[jtag_pkg::BIT_AW-1:0];

    always_ff @(posedge JTAG_CLK)
    begin
        if (core_rst)
        begin
            state <= jtag_pkg::TEST_LOGIC_RESET;
            rst_cnt <= 8'd0;
            bit_cnt <= 33'd0;
            word_cnt <= 16'd0;
            word_base <= 32'd0;
            active <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            done <= reset_done || scan_done;
            if (state == jtag_pkg::TEST_LOGIC_RESET)
                rst_cnt <= rst_cnt + 8'd1;
            else
                rst_cnt <= 8'd0;
            if (ctrl.shifting && !last_shift)
                bit_cnt <= bit_cnt + 33'd1;
            else
                bit_cnt <= 33'd0;
            if (launch)
            begin
                active <= 1'b1;
                word_cnt <= 16'd0;
                word_base <= 32'd0;
            end
            else if (scan_done)
                active <= 1'b0;
            else if (state inside {jtag_pkg::UPDATE_DR, jtag_pkg::UPDATE_IR})
            begin
                word_cnt <= word_cnt + 16'd1;
                word_base <= word_base + 32'(conf.bit_count);
            end
        end
    end

    // Data bits of all words must fit in the buffer
    a_addr_in_range: assert property (@(posedge JTAG_CLK) disable iff (core_rst)
        ctrl.data_bit |-> addr_full < 32'(8 * `JTAG_MEM_BYTES));

endmodule

//--- verilog/jtag_pin_driver.sv
`timescale 1ns/1ps

module jtag_pin_driver (
    input  logic                          JTAG_CLK,
    input  logic                          core_rst,
    input  jtag_pkg::shift_ctrl_t         ctrl,
    input  logic                          sdi_bit,
    input  logic                          tdo,
    output logic                          tck,
    output logic                          tms,
    output logic                          tdi,
    output logic                          sen,
    output logic                          sld,
    output logic                          cap_we,
    output logic [jtag_pkg::BIT_AW-1:0]   cap_addr
);

    logic tdi_d;
    logic gate_en;
    logic tdo_q;
    logic [1:0] sen_hist;

    assign tdi_d = sdi_bit & ctrl.data_bit;   // Zero during the wait part

    always_ff @(negedge JTAG_CLK)
    begin
        if (core_rst)
        begin
            tms <= 1'b1;
            sen <= 1'b0;
            tdi <= 1'b0;
            cap_we <= 1'b0;
        end
        else
        begin
            tms <= ctrl.tms;
            sen <= ctrl.sen;
            tdi <= tdi_d;
            cap_we <= ctrl.sen && ctrl.shifting && ctrl.data_bit;
        end
    end

    // Capture index follows the TDI bit
    always_ff @(negedge JTAG_CLK)
        cap_addr <= ctrl.bit_addr;

    // Glitch-free clock gate, enable latched while the clock is low
    always_latch
    begin
        if (!JTAG_CLK)
            gate_en <= sen;
    end

    assign tck = JTAG_CLK & gate_en;

    always_ff @(posedge JTAG_CLK)
        tdo_q <= tdo;

    always_ff @(posedge JTAG_CLK)
    begin
        if (core_rst)
        begin
            sen_hist <= 2'b00;
            sld <= 1'b0;
        end
        else
        begin
            sen_hist <= {sen_hist[0], sen};
            sld <= sen_hist[1] && !sen_hist[0];   // Load pulse after the last TCK
        end
    end

    a_tdi_quiet: assert property (@(posedge JTAG_CLK) disable iff (core_rst) !sen |-> !tdi);

    // Loopback view of the captured bit, for debug only
    a_tdo_known: assert property (@(posedge JTAG_CLK) disable iff (core_rst)
        cap_we |=> !$isunknown(tdo_q));

endmodule

//--- verilog/jtag_master_top.sv
`timescale 1ns/1ps
`include "jtag_defs.svh"

module jtag_master_top (
    input  logic                          JTAG_CLK,
    input  logic                          RST_SYNC,
    input  logic [`JTAG_ABUSWIDTH-1:0]    bus_add,
    input  logic [7:0]                    bus_data_in,
    input  logic                          bus_wr,
    input  logic                          bus_rd,
    output logic [7:0]                    bus_data_out,
    output logic                          tck,
    input  logic                          tdo,
    output logic                          tdi,
    output logic                          tms,
    output logic                          sen,
    output logic                          sld
);

    jtag_pkg::jtag_conf_t conf;
    jtag_pkg::shift_ctrl_t ctrl;
    logic start;
    logic done;
    logic core_rst;
    logic out_mem_we;
    logic [jtag_pkg::BYTE_AW-1:0] mem_addr;
    logic [7:0] in_mem_data;
    logic [7:0] out_mem_data;
    logic sdi_bit;
    logic cap_we;
    logic [jtag_pkg::BIT_AW-1:0] cap_addr;

    jtag_regs i_jtag_regs (
        .JTAG_CLK     (JTAG_CLK),
        .RST_SYNC     (RST_SYNC),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .in_mem_data  (in_mem_data),
        .out_mem_data (out_mem_data),
        .done         (done),
        .conf         (conf),
        .start        (start),
        .core_rst     (core_rst),
        .out_mem_we   (out_mem_we),
        .out_mem_addr (mem_addr),
        .bus_data_out (bus_data_out)
    );

    // Outgoing stream, written by the bus
    jtag_bit_mem i_out_mem (
        .JTAG_CLK   (JTAG_CLK),
        .byte_we    (out_mem_we),
        .byte_addr  (mem_addr),
        .byte_wdata (bus_data_in),
        .byte_rdata (out_mem_data),
        .bit_we     (1'b0),
        .bit_addr   (ctrl.bit_addr),
        .bit_wdata  (1'b0),
        .bit_rdata  (sdi_bit)
    );

    // Captured TDO, read-only from the bus
    jtag_bit_mem i_in_mem (
        .JTAG_CLK   (JTAG_CLK),
        .byte_we    (1'b0),
        .byte_addr  (mem_addr),
        .byte_wdata (bus_data_in),
        .byte_rdata (in_mem_data),
        .bit_we     (cap_we),
        .bit_addr   (cap_addr),
        .bit_wdata  (tdo),
        .bit_rdata  ()
    );

    jtag_tap_sequencer i_jtag_tap_sequencer (
        .JTAG_CLK (JTAG_CLK),
        .core_rst (core_rst),
        .conf     (conf),
        .start    (start),
        .ctrl     (ctrl),
        .done     (done)
    );

    jtag_pin_driver i_jtag_pin_driver (
        .JTAG_CLK (JTAG_CLK),
        .core_rst (core_rst),
        .ctrl     (ctrl),
        .sdi_bit  (sdi_bit),
        .tdo      (tdo),
        .tck      (tck),
        .tms      (tms),
        .tdi      (tdi),
        .sen      (sen),
        .sld      (sld),
        .cap_we   (cap_we),
        .cap_addr (cap_addr)
    );

endmodule

//--- verif/tb_jtag_master.sv
`timescale 1ns/1ps
`include "jtag_defs.svh"

module tb_jtag_master;

    localparam int AW = `JTAG_ABUSWIDTH;
    localparam int MEM = `JTAG_MEM_BYTES;
    localparam int NBITS = 8 * `JTAG_MEM_BYTES;

    logic JTAG_CLK;
    logic RST_SYNC;
    logic [AW-1:0] bus_add;
    logic [7:0] bus_data_in;
    logic bus_wr;
    logic bus_rd;
    logic [7:0] bus_data_out;
    logic tck;
    logic tdo;
    logic tdi;
    logic tms;
    logic sen;
    logic sld;

    logic [7:0] regs_model [16];
    logic [7:0] out_model [MEM];
    logic seen_tms [$];
    logic seen_tdi [$];
    logic seen_sen [$];
    logic exp_tms [$];
    logic exp_tdi [$];
    int sld_cnt;
    int cycle_cnt;
    int cycle_limit;
    int err_cnt;

    always #2 JTAG_CLK = ~JTAG_CLK;

    assign tdo = tdi;   // Loopback

    jtag_master_top i_jtag_master_top (
        .JTAG_CLK     (JTAG_CLK),
        .RST_SYNC     (RST_SYNC),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .tck          (tck),
        .tdo          (tdo),
        .tdi          (tdi),
        .tms          (tms),
        .sen          (sen),
        .sld          (sld)
    );

    // What the TAP sees on each TCK rise
    always @(posedge tck)
    begin
        seen_tms.push_back(tms);
        seen_tdi.push_back(tdi);
        seen_sen.push_back(sen);
    end

    always @(posedge JTAG_CLK)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (sld === 1'b1)
            sld_cnt = sld_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            err_cnt++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic clear_monitor();
        seen_tms.delete();
        seen_tdi.delete();
        seen_sen.delete();
        sld_cnt = 0;
    endtask

    task automatic model_reset();
        for (int i = 0; i < 16; i++)
            regs_model[i] = 8'h00;
        regs_model[3] = 8'((8 * MEM) % 256);
        regs_model[4] = 8'((8 * MEM) / 256);
        regs_model[9] = 8'd1;
    endtask

    task automatic bus_write(input logic [AW-1:0] addr, input logic [7:0] data);
        bus_add = addr;
        bus_data_in = data;
        bus_wr = 1'b1;
        @(posedge JTAG_CLK);
        #1;
        bus_wr = 1'b0;
        if (addr == 0)
        begin
            model_reset();
            clear_monitor();   // TAP reset sequence follows
        end
        else if (addr < 16)
            regs_model[addr[3:0]] = data;
        else if (addr < 16 + MEM)
            out_model[addr - 16] = data;
    endtask

    task automatic bus_read(input logic [AW-1:0] addr, output logic [7:0] data);
        bus_add = addr;
        bus_rd = 1'b1;
        @(posedge JTAG_CLK);
        #1;
        bus_rd = 1'b0;
        data = bus_data_out;
    endtask

    task automatic wait_done();
        logic [7:0] flag;
        flag = 8'h00;
        while (flag[0] !== 1'b1)
            bus_read(1, flag);
        repeat (2) @(posedge JTAG_CLK);
        #1;
    endtask

    // Stream bit j sits in byte j/8 at bit 7-j%8
    function automatic logic sent_bit(input int j);
        return out_model[j / 8][7 - j % 8];
    endfunction

    task automatic push_step(input logic tms_v, input logic tdi_v);
        exp_tms.push_back(tms_v);
        exp_tdi.push_back(tdi_v);
    endtask

    task automatic build_scan();
        int bc;
        int wc;
        int words;
        int n;
        logic ir;
        bc = {regs_model[4], regs_model[3]};
        wc = {regs_model[8], regs_model[7], regs_model[6], regs_model[5]};
        words = {regs_model[10], regs_model[9]};
        ir = ({regs_model[12], regs_model[11]} == 16'd0);
        n = bc + wc;
        exp_tms.delete();
        exp_tdi.delete();
        for (int w = 0; w < words; w++)
        begin
            push_step(1'b1, 1'b0);      // Select-DR
            if (ir)
                push_step(1'b1, 1'b0);  // Select-IR
            push_step(1'b0, 1'b0);
            push_step(1'b0, 1'b0);      // Into shift
            for (int k = 0; k < n; k++)
            begin
                if (k < bc)
                    push_step(k == n - 1, sent_bit((w * bc + bc - 1 - k) % NBITS));
                else
                    push_step(k == n - 1, 1'b0);
            end
            push_step(1'b1, 1'b0);      // Update
            push_step(1'b0, 1'b0);
        end
    endtask

    task automatic compare_tap();
        check_value("tck_edges", seen_tms.size(), exp_tms.size());
        for (int i = 0; i < exp_tms.size(); i++)
        begin
            check_value($sformatf("tms[%0d]", i), seen_tms[i], exp_tms[i]);
            check_value($sformatf("tdi[%0d]", i), seen_tdi[i], exp_tdi[i]);
            check_value($sformatf("sen[%0d]", i), seen_sen[i], 1'b1);
        end
        check_value("sen", sen, 1'b0);   // Idle after the sequence
        check_value("sld_pulses", sld_cnt, 1);
    endtask

    task automatic check_tap_reset();
        exp_tms.delete();
        exp_tdi.delete();
        for (int i = 0; i < `JTAG_RESET_TMS; i++)
            push_step(1'b1, 1'b0);
        push_step(1'b0, 1'b0);
        wait_done();
        compare_tap();
    endtask

    task automatic run_scan();
        logic [7:0] flag;
        build_scan();
        clear_monitor();
        bus_write(1, 8'h01);
        bus_read(1, flag);
        check_value("done_flag", flag[0], 1'b0);
        wait_done();
        compare_tap();
    endtask

    task automatic run_record(input logic [8*16-1:0] cmd, input logic [AW-1:0] addr,
                              input logic [7:0] data);
        logic [7:0] got;
        case (cmd)
            "wr": bus_write(addr, data);
            "rd":
            begin
                bus_read(addr, got);
                check_value($sformatf("bus_data_out@%0h", addr), got, data);
            end
            "scan": run_scan();
            "tapreset": check_tap_reset();
            default:
            begin
                $display("Unknown command in the stimulus file");
                $display("Something failed");
                $fatal(1);
            end
        endcase
    endtask

    // One pass counts the records, the next one runs them
    task automatic run_file(input bit execute, output int records);
        integer fd;
        integer code;
        logic [8*16-1:0] cmd;
        logic [8*128-1:0] rest;
        logic [AW-1:0] addr;
        logic [7:0] data;
        records = 0;
        fd = $fopen("verif/jtag_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file verif/jtag_stim.txt");
            $display("Something failed");
            $fatal(1);
        end
        else
        begin
            while (!$feof(fd))
            begin
                cmd = '0;
                addr = '0;
                data = '0;
                code = $fscanf(fd, "%s", cmd);
                if (code == 1 && cmd != "#")
                begin
                    records++;
                    if (cmd == "wr" || cmd == "rd")
                        code = $fscanf(fd, "%h %h", addr, data);
                    if (execute)
                        run_record(cmd, addr, data);
                end
                code = $fgets(rest, fd);
            end
            $fclose(fd);
        end
    endtask

    initial
    begin
        int recs;
        JTAG_CLK = 1'b0;
        RST_SYNC = 1'b1;
        bus_add = '0;
        bus_data_in = 8'h00;
        bus_wr = 1'b0;
        bus_rd = 1'b0;
        cycle_cnt = 0;
        cycle_limit = 0;
        err_cnt = 0;
        sld_cnt = 0;
        model_reset();
        run_file(1'b0, recs);
        cycle_limit = recs * 600;
        repeat (4) @(posedge JTAG_CLK);
        #1;
        RST_SYNC = 1'b0;
        clear_monitor();
        run_file(1'b1, recs);
        if (err_cnt == 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
        begin
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule

//--- verif/jtag_stim.txt
# cmd addr data, hex. wr is a bus write, rd a bus read with expected data
# scan starts a scan and checks it, tapreset waits for the TAP reset sequence
tapreset
rd 00 01
rd 01 01
rd 02 00
rd 03 80
rd 04 00
rd 05 00
rd 06 00
rd 07 00
rd 08 00
rd 09 01
rd 0a 00
rd 0b 00
rd 0c 00
rd 0d 00
rd 0e 10
rd 0f 00
wr 10 a5
wr 11 3c
wr 12 96
rd 11 3c
wr 03 10
wr 05 03
wr 0b 01
scan
rd 20 a5
rd 21 3c
wr 03 05
wr 05 02
wr 0b 00
scan
rd 20 a5
wr 10 5a
wr 11 c3
wr 12 69
wr 03 08
wr 05 01
wr 09 03
wr 0b 01
scan
rd 10 5a
rd 20 5a
rd 21 c3
rd 22 69
rd 01 01
wr 00 00
tapreset
rd 03 80
rd 04 00
rd 05 00
rd 09 01
rd 0b 00

//--- filelist.f
+incdir+verilog
verilog/jtag_pkg.sv
verilog/jtag_regs.sv
verilog/jtag_bit_mem.sv
verilog/jtag_tap_sequencer.sv
verilog/jtag_pin_driver.sv
verilog/jtag_master_top.sv
verif/tb_jtag_master.sv

//--- Bender.yml
package:
  name: jtag_master

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/jtag_pkg.sv
      - verilog/jtag_regs.sv
      - verilog/jtag_bit_mem.sv
      - verilog/jtag_tap_sequencer.sv
      - verilog/jtag_pin_driver.sv
      - verilog/jtag_master_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_jtag_master.sv
